//--- compile.f
+incdir+dv
source/l2_ctrl_pkg.sv
source/l2_tag_store.sv
source/l2_lru_age.sv
source/l2_ctrl_fsm.sv
source/l2_controller.sv
dv/l2_ctrl_tb.sv

//--- Bender.yml
package:
  name: l2_controller

sources:
  - files:
      - source/l2_ctrl_pkg.sv
      - source/l2_tag_store.sv
      - source/l2_lru_age.sv
      - source/l2_ctrl_fsm.sv
      - source/l2_controller.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/l2_ctrl_tb.sv

//--- dv/l2_ctrl_ref.svh
`ifndef L2_CTRL_REF_SVH
`define L2_CTRL_REF_SVH

// expected outcome of one request
typedef struct packed {
    logic                is_write;
    logic                hit;
    logic                wb;
    l2_ctrl_pkg::way_t   way;
    l2_ctrl_pkg::index_t index;
    l2_ctrl_pkg::tag_t   tag;
    l2_ctrl_pkg::tag_t   wb_tag;
} exp_txn_t;

l2_ctrl_pkg::tag_t ref_tag   [l2_ctrl_pkg::num_sets][l2_ctrl_pkg::num_ways];
logic              ref_valid [l2_ctrl_pkg::num_sets][l2_ctrl_pkg::num_ways];
logic              ref_dirty [l2_ctrl_pkg::num_sets][l2_ctrl_pkg::num_ways];
l2_ctrl_pkg::age_t ref_age   [l2_ctrl_pkg::num_sets][l2_ctrl_pkg::num_ways];

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// way w starts at age w
function automatic void ref_init();
    for (int s = 0; s < l2_ctrl_pkg::num_sets; s++)
    begin
        for (int w = 0; w < l2_ctrl_pkg::num_ways; w++)
        begin
            ref_tag[s][w]   = '0;
            ref_valid[s][w] = 1'b0;
            ref_dirty[s][w] = 1'b0;
            ref_age[s][w]   = l2_ctrl_pkg::age_t'(w);
        end
    end
endfunction

// ages survive a flush
function automatic void ref_flush();
    for (int s = 0; s < l2_ctrl_pkg::num_sets; s++)
    begin
        for (int w = 0; w < l2_ctrl_pkg::num_ways; w++)
        begin
            ref_valid[s][w] = 1'b0;
            ref_dirty[s][w] = 1'b0;
        end
    end
endfunction

function automatic void ref_touch(input l2_ctrl_pkg::index_t idx, input l2_ctrl_pkg::way_t w);
    l2_ctrl_pkg::age_t old_age;
    old_age = ref_age[idx][w];
    for (int v = 0; v < l2_ctrl_pkg::num_ways; v++)
    begin
        if (ref_age[idx][v] < old_age)
            ref_age[idx][v] = ref_age[idx][v] + 1'b1;
    end
    ref_age[idx][w] = '0;
endfunction

function automatic exp_txn_t ref_access(input logic is_write, input l2_ctrl_pkg::index_t idx,
                                        input l2_ctrl_pkg::tag_t tg);
    exp_txn_t e;
    logic     found_free;
    e          = '0;
    e.is_write = is_write;
    e.index    = idx;
    e.tag      = tg;
    found_free = 1'b0;
    for (int w = 0; w < l2_ctrl_pkg::num_ways; w++)
    begin
        if (!e.hit && ref_valid[idx][w] && ref_tag[idx][w] == tg)
        begin
            e.hit = 1'b1;
            e.way = l2_ctrl_pkg::way_t'(w);
        end
    end
    if (!e.hit)
    begin
        // lowest invalid way, else the oldest
        for (int w = 0; w < l2_ctrl_pkg::num_ways; w++)
        begin
            if (!found_free && !ref_valid[idx][w])
            begin
                found_free = 1'b1;
                e.way      = l2_ctrl_pkg::way_t'(w);
            end
        end
        for (int w = 0; w < l2_ctrl_pkg::num_ways; w++)
        begin
            if (!found_free && ref_age[idx][w] == 2'd3)
                e.way = l2_ctrl_pkg::way_t'(w);
        end
        e.wb                   = ref_valid[idx][e.way] && ref_dirty[idx][e.way];
        e.wb_tag               = ref_tag[idx][e.way];
        ref_tag[idx][e.way]    = tg;
        ref_valid[idx][e.way]  = 1'b1;
        ref_dirty[idx][e.way]  = 1'b0;
    end
    ref_touch(idx, e.way);
    if (is_write)
        ref_dirty[idx][e.way] = 1'b1;
    return e;
endfunction

task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first failure");
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want)
    begin
        $display("** Error %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        abort_run();
    end
endtask

task automatic check_way(input string name, input l2_ctrl_pkg::way_t got,
                         input l2_ctrl_pkg::way_t want);
    if (got !== want)
    begin
        $display("** Error %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        abort_run();
    end
endtask

task automatic check_tag(input string name, input l2_ctrl_pkg::tag_t got,
                         input l2_ctrl_pkg::tag_t want);
    if (got !== want)
    begin
        $display("** Error %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        abort_run();
    end
endtask

task automatic check_index(input string name, input l2_ctrl_pkg::index_t got,
                           input l2_ctrl_pkg::index_t want);
    if (got !== want)
    begin
        $display("** Error %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        abort_run();
    end
endtask

`endif

//--- dv/l2_ctrl_tb.sv
`timescale 1ns/1ps

module l2_ctrl_tb;

    localparam logic [31:0] lcg_seed      = 32'h73c442bc;
    localparam int          ready_timeout = 200;
    localparam int          rand_txns     = 400;

    logic                     clk;
    logic                     nrst;
    l2_ctrl_pkg::l2_req_t     req;
    logic                     flush;
    logic                     mem_ready;
    logic                     ready;
    logic                     refill;
    logic                     update;
    logic                     mem_read;
    logic                     mem_write;
    l2_ctrl_pkg::l2_mem_req_t mem_req;
    l2_ctrl_pkg::way_t        way;

    `include "l2_ctrl_ref.svh"

    exp_txn_t    exp_q [$];
    int          issued;
    int          checked;
    logic        reset_phase;
    logic [31:0] stim_state;

    l2_controller dut_i (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .flush     (flush),
        .mem_ready (mem_ready),
        .ready     (ready),
        .refill    (refill),
        .update    (update),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_req   (mem_req),
        .way       (way)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory answers each strobe after 1 to 8 cycles
    initial
    begin : mem_responder
        logic [31:0] mstate;
        int          delay;
        mem_ready = 1'b0;
        mstate    = lcg_seed;
        forever
        begin
            @(posedge clk);
            if (mem_read || mem_write)
            begin
                mstate = lcg_next(mstate);
                delay  = 1 + mstate[18:16];
                repeat (delay - 1) @(posedge clk);
                mem_ready <= 1'b1;
                @(posedge clk);
                mem_ready <= 1'b0;
            end
        end
    end

    task automatic issue(input logic is_write, input l2_ctrl_pkg::index_t idx,
                         input l2_ctrl_pkg::tag_t tg);
        int waited;
        exp_q.push_back(ref_access(is_write, idx, tg));
        issued++;
        @(posedge clk);
        req.read  <= !is_write;
        req.write <= is_write;
        req.index <= idx;
        req.tag   <= tg;
        waited = 0;
        @(negedge clk);
        while (!ready)
        begin
            waited++;
            if (waited > ready_timeout)
            begin
                $display("no ready for request to set 0x%0h within %0d cycles", idx, waited);
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        req.read  <= 1'b0;
        req.write <= 1'b0;
    endtask

    task automatic do_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        ref_flush();
    endtask

    initial
    begin : compare_proc
        exp_txn_t cur;
        int       ncyc;
        int       wr_first;
        int       rd_first;
        int       refills;
        logic     rd_done_prev;
        ncyc         = 0;
        wr_first     = 0;
        rd_first     = 0;
        refills      = 0;
        rd_done_prev = 1'b0;
        forever
        begin
            @(negedge clk);
            if (!req.read && !req.write)
            begin
                check_bit("ready", ready, 1'b0);
                check_bit("refill", refill, 1'b0);
                check_bit("update", update, 1'b0);
                check_bit("mem_read", mem_read, 1'b0);
                check_bit("mem_write", mem_write, 1'b0);
                if (reset_phase)
                    check_way("way", way, '0);
            end
            else
            begin
                if (exp_q.size() == 0)
                begin
                    $display("request seen on the bus with no prediction queued");
                    abort_run();
                end
                cur = exp_q[0];
                ncyc++;
                if (mem_write)
                begin
                    check_bit("mem_write", 1'b1, cur.wb);
                    if (wr_first == 0)
                        wr_first = ncyc;
                    check_tag("mem_req.wb_tag", mem_req.wb_tag, cur.wb_tag);
                end
                if (mem_read)
                begin
                    if (rd_first == 0)
                        rd_first = ncyc;
                    check_index("mem_req.index", mem_req.index, cur.index);
                    check_tag("mem_req.tag", mem_req.tag, cur.tag);
                end
                if (refill)
                begin
                    refills++;
                    check_bit("refill after allocate mem_ready", rd_done_prev, 1'b1);
                end
                if (update)
                    check_bit("ready with update", ready, 1'b1);
                if (ready)
                begin
                    check_way("way", way, cur.way);
                    check_bit("update", update, cur.is_write);
                    check_bit("mem_read seen", rd_first != 0, !cur.hit);
                    check_bit("mem_write seen", wr_first != 0, cur.wb);
                    if (wr_first != 0)
                        check_bit("mem_write before mem_read", wr_first < rd_first, 1'b1);
                    check_bit("refill seen", refills != 0, !cur.hit);
                    check_bit("refill repeated", refills > 1, 1'b0);
                    if (cur.hit)
                        check_bit("hit ready after 4 cycles", ncyc == 4, 1'b1);
                    void'(exp_q.pop_front());
                    checked++;
                    ncyc     = 0;
                    wr_first = 0;
                    rd_first = 0;
                    refills  = 0;
                end
            end
            rd_done_prev = mem_read && mem_ready;
        end
    end

    initial
    begin : stimulus
        logic [31:0] r;
        nrst        = 1'b0;
        req         = '0;
        flush       = 1'b0;
        issued      = 0;
        checked     = 0;
        reset_phase = 1'b1;
        stim_state  = lcg_seed;
        ref_init();
        repeat (16) @(posedge clk);
        nrst <= 1'b1;
        repeat (3) @(posedge clk);
        reset_phase = 1'b0;

        // empty set, then a repeat hit
        issue(1'b0, 8'h21, 18'h00a11);
        issue(1'b0, 8'h21, 18'h00a11);

        // five tags into one set, then the evicted one again
        for (int i = 0; i < 5; i++)
            issue(1'b0, 8'h40, 18'h01000 + i);
        issue(1'b0, 8'h40, 18'h01000);

        // dirty line aged out and written back
        for (int i = 0; i < 4; i++)
            issue(1'b0, 8'h55, 18'h02000 + i);
        issue(1'b1, 8'h55, 18'h02000);
        for (int i = 1; i < 4; i++)
            issue(1'b0, 8'h55, 18'h02000 + i);
        issue(1'b1, 8'h55, 18'h02001);
        issue(1'b0, 8'h55, 18'h02005);

        // flush drops dirty lines without write-back
        do_flush();
        issue(1'b0, 8'h55, 18'h02001);
        issue(1'b0, 8'h40, 18'h01004);
        issue(1'b0, 8'h21, 18'h00a11);

        for (int i = 0; i < rand_txns; i++)
        begin
            stim_state = lcg_next(stim_state);
            r = stim_state;
            if (r[15:12] == 4'h0)
                do_flush();
            issue(r[20], 8'h10 + r[25:24], 18'h2a000 + (r[30:28] % 6));
        end

        repeat (4) @(posedge clk);
        if (checked == issued && exp_q.size() == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("%0d requests issued but %0d completed", issued, checked);
            abort_run();
        end
    end

endmodule

//--- source/l2_controller.sv
`timescale 1ns/1ps

module l2_controller (
    input  logic                     clk,
    input  logic                     nrst,
    input  l2_ctrl_pkg::l2_req_t     req,
    input  logic                     flush,
    input  logic                     mem_ready,
    output logic                     ready,
    output logic                     refill,
    output logic                     update,
    output logic                     mem_read,
    output logic                     mem_write,
    output l2_ctrl_pkg::l2_mem_req_t mem_req,
    output l2_ctrl_pkg::way_t        way
);

    l2_ctrl_pkg::l2_tag_cmd_t cmd;
    l2_ctrl_pkg::l2_lookup_t  lookup;
    l2_ctrl_pkg::tag_t        wb_tag;
    l2_ctrl_pkg::way_t        victim_way;
    logic                     touch;

    // refill address is the request itself
    assign mem_req.index  = req.index;
    assign mem_req.tag    = req.tag;
    assign mem_req.wb_tag = wb_tag;

    l2_tag_store tag_store_i (
        .clk    (clk),
        .nrst   (nrst),
        .index  (req.index),
        .tag    (req.tag),
        .cmd    (cmd),
        .lookup (lookup),
        .wb_tag (wb_tag)
    );

    l2_lru_age lru_age_i (
        .clk        (clk),
        .nrst       (nrst),
        .index      (req.index),
        .touch      (touch),
        .touch_way  (cmd.way),
        .victim_way (victim_way)
    );

    l2_ctrl_fsm ctrl_fsm_i (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .flush      (flush),
        .mem_ready  (mem_ready),
        .lookup     (lookup),
        .victim_way (victim_way),
        .cmd        (cmd),
        .touch      (touch),
        .ready      (ready),
        .refill     (refill),
        .update     (update),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .way        (way)
    );

endmodule

//--- source/l2_ctrl_fsm.sv
`timescale 1ns/1ps

module l2_ctrl_fsm (
    input  logic                     clk,
    input  logic                     nrst,
    input  l2_ctrl_pkg::l2_req_t     req,
    input  logic                     flush,
    input  logic                     mem_ready,
    input  l2_ctrl_pkg::l2_lookup_t  lookup,
    input  l2_ctrl_pkg::way_t        victim_way,
    output l2_ctrl_pkg::l2_tag_cmd_t cmd,
    output logic                     touch,
    output logic                     ready,
    output logic                     refill,
    output logic                     update,
    output logic                     mem_read,
    output logic                     mem_write,
    output l2_ctrl_pkg::way_t        way
);

    l2_ctrl_pkg::l2_state_e state;
    l2_ctrl_pkg::l2_state_e next_state;
    l2_ctrl_pkg::way_t      way_q;
    l2_ctrl_pkg::way_t      sel_way;
    logic                   req_valid;
    logic                   wb_needed;

    assign req_valid = req.read || req.write;

    // hit way, else first free way, else lru victim
    assign sel_way = lookup.hit ? lookup.hit_way :
                     lookup.has_free ? lookup.free_way : victim_way;
    assign wb_needed = lookup.valid[sel_way] && lookup.dirty[sel_way];

    always_comb
    begin
        next_state = state;
        case (state)
            l2_ctrl_pkg::st_idle:
                // requester still holds req during the ready cycle
                if (req_valid && !ready)
                    next_state = l2_ctrl_pkg::st_compare;
            l2_ctrl_pkg::st_compare:
                if (lookup.hit)
                    next_state = l2_ctrl_pkg::st_respond;
                else if (wb_needed)
                    next_state = l2_ctrl_pkg::st_write_back;
                else
                    next_state = l2_ctrl_pkg::st_allocate;
            l2_ctrl_pkg::st_write_back:
                if (mem_ready)
                    next_state = l2_ctrl_pkg::st_allocate;
            l2_ctrl_pkg::st_allocate:
                if (mem_ready)
                    next_state = l2_ctrl_pkg::st_compare;
            l2_ctrl_pkg::st_respond:
                next_state = l2_ctrl_pkg::st_idle;
            default:
                next_state = l2_ctrl_pkg::st_idle;
        endcase
    end

    always_comb
    begin
        cmd.fill       = (state == l2_ctrl_pkg::st_allocate) && mem_ready;
        cmd.mark_dirty = (state == l2_ctrl_pkg::st_compare) && lookup.hit && req.write;
        cmd.clear_all  = (state == l2_ctrl_pkg::st_idle) && flush && !req_valid;
        cmd.way        = (state == l2_ctrl_pkg::st_compare) ? lookup.hit_way : way_q;
    end

    assign touch     = (state == l2_ctrl_pkg::st_compare) && lookup.hit;
    assign mem_read  = (state == l2_ctrl_pkg::st_allocate);
    assign mem_write = (state == l2_ctrl_pkg::st_write_back);
    assign way       = way_q;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state  <= l2_ctrl_pkg::st_idle;
            way_q  <= '0;
            ready  <= 1'b0;
            update <= 1'b0;
            refill <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (state == l2_ctrl_pkg::st_compare)
            begin
                way_q <= sel_way;
            end
            ready  <= (state == l2_ctrl_pkg::st_respond);
            update <= (state == l2_ctrl_pkg::st_respond) && req.write;
            refill <= (state == l2_ctrl_pkg::st_allocate) && mem_ready;
        end
    end

    // fill and write-back use the held request tag and index
    req_held_in_flight: assert property (
        @(posedge clk) disable iff (!nrst)
        (state != l2_ctrl_pkg::st_idle) |-> $stable(req)
    );

    // memory answers only an active strobe
    mem_ready_on_strobe: assert property (
        @(posedge clk) disable iff (!nrst)
        mem_ready |-> (mem_read || mem_write)
    );

endmodule

//--- source/l2_lru_age.sv
`timescale 1ns/1ps

module l2_lru_age (
    input  logic                clk,
    input  logic                nrst,
    input  l2_ctrl_pkg::index_t index,
    input  logic                touch,
    input  l2_ctrl_pkg::way_t   touch_way,
    output l2_ctrl_pkg::way_t   victim_way
);

    typedef l2_ctrl_pkg::age_t [l2_ctrl_pkg::num_ways-1:0] set_ages_t;

    set_ages_t ages [l2_ctrl_pkg::num_sets];
    set_ages_t cur_ages;
    set_ages_t next_ages;

    function automatic logic ages_distinct(input set_ages_t a);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < l2_ctrl_pkg::num_ways; i++)
        begin
            for (int j = i + 1; j < l2_ctrl_pkg::num_ways; j++)
            begin
                if (a[i] == a[j])
                begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    assign cur_ages = ages[index];

    // ways younger than the touched one move up by one
    always_comb
    begin
        for (int w = 0; w < l2_ctrl_pkg::num_ways; w++)
        begin
            if (l2_ctrl_pkg::way_t'(w) == touch_way)
                next_ages[w] = '0;
            else if (cur_ages[w] < cur_ages[touch_way])
                next_ages[w] = cur_ages[w] + 1'b1;
            else
                next_ages[w] = cur_ages[w];
        end
    end

    // oldest way has age 3
    always_comb
    begin
        victim_way = '0;
        for (int w = 0; w < l2_ctrl_pkg::num_ways; w++)
        begin
            if (cur_ages[w] == 2'd3)
            begin
                victim_way = l2_ctrl_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < l2_ctrl_pkg::num_sets; s++)
            begin
                ages[s] <= l2_ctrl_pkg::age_reset;
            end
        end
        else if (touch)
        begin
            ages[index] <= next_ages;
        end
    end

    ages_stay_permutation: assert property (
        @(posedge clk) disable iff (!nrst)
        touch |=> ages_distinct(ages[$past(index)])
    );

endmodule

//--- source/l2_tag_store.sv
`timescale 1ns/1ps

module l2_tag_store (
    input  logic                     clk,
    input  logic                     nrst,
    input  l2_ctrl_pkg::index_t      index,
    input  l2_ctrl_pkg::tag_t        tag,
    input  l2_ctrl_pkg::l2_tag_cmd_t cmd,
    output l2_ctrl_pkg::l2_lookup_t  lookup,
    output l2_ctrl_pkg::tag_t        wb_tag
);

    localparam int num_lines = l2_ctrl_pkg::num_sets * l2_ctrl_pkg::num_ways;
    localparam int line_w    = $bits(l2_ctrl_pkg::index_t) + $bits(l2_ctrl_pkg::way_t);

    typedef logic [line_w-1:0] line_t;

    l2_ctrl_pkg::tag_t                tags [num_lines];
    logic [num_lines-1:0]             valid;
    logic [num_lines-1:0]             dirty;
    logic [l2_ctrl_pkg::num_ways-1:0] match;
    line_t                            cmd_line;

    // line address is set index with way in the low bits
    assign cmd_line = {index, cmd.way};
    assign wb_tag   = tags[cmd_line];

    // walk ways from high to low so the lowest invalid way wins
    always_comb
    begin
        lookup = '0;
        match  = '0;
        for (int w = l2_ctrl_pkg::num_ways - 1; w >= 0; w--)
        begin
            line_t line;
            line = {index, l2_ctrl_pkg::way_t'(w)};
            lookup.valid[w] = valid[line];
            lookup.dirty[w] = dirty[line];
            match[w] = valid[line] && (tags[line] == tag);
            if (match[w])
            begin
                lookup.hit     = 1'b1;
                lookup.hit_way = l2_ctrl_pkg::way_t'(w);
            end
            if (!valid[line])
            begin
                lookup.has_free = 1'b1;
                lookup.free_way = l2_ctrl_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd.fill)
        begin
            tags[cmd_line] <= tag;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (cmd.clear_all)
        begin
            // flush drops dirty data too
            valid <= '0;
            dirty <= '0;
        end
        else
        begin
            if (cmd.fill)
            begin
                valid[cmd_line] <= 1'b1;
                dirty[cmd_line] <= 1'b0;
            end
            if (cmd.mark_dirty)
            begin
                dirty[cmd_line] <= 1'b1;
            end
        end
    end

    // fsm never fills and writes the same cycle
    fill_not_with_mark: assert property (
        @(posedge clk) disable iff (!nrst)
        !(cmd.fill && cmd.mark_dirty)
    );

endmodule

//--- source/l2_ctrl_pkg.sv
package l2_ctrl_pkg;

    localparam int tag_w    = 18;
    localparam int index_w  = 8;
    localparam int num_sets = 256;
    localparam int num_ways = 4;

    // way 3 oldest, way 0 youngest
    localparam logic [7:0] age_reset = 8'b11_10_01_00;

    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [1:0]         way_t;
    typedef logic [1:0]         age_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_allocate,
        st_respond
    } l2_state_e;

    typedef struct packed {
        logic   read;
        logic   write;
        index_t index;
        tag_t   tag;
    } l2_req_t;

    typedef struct packed {
        index_t index;
        tag_t   tag;
        tag_t   wb_tag;
    } l2_mem_req_t;

    typedef struct packed {
        logic                hit;
        way_t                hit_way;
        logic                has_free;
        way_t                free_way;
        logic [num_ways-1:0] dirty;
        logic [num_ways-1:0] valid;
    } l2_lookup_t;

    typedef struct packed {
        logic fill;
        logic mark_dirty;
        logic clear_all;
        way_t way;
    } l2_tag_cmd_t;

endpackage
